// File: haar_db.f
+incdir+.
haar_db_pkg.sv
haar_db_launch.sv
haar_db_stage.sv
haar_db_done.sv
haar_db.sv
haar_db_tb.sv

// File: haar_db.mem
// One word per line: digit A, B or C marks the stage, F a threshold word, then the address.
A00
A01
A02
A03
A04
A05
A06
A07
A08
A09
A0A
A0B
A0C
A0D
A0E
A0F
A10
A11
F12
F13
F14
B15
B16
B17
B18
B19
B1A
B1B
B1C
B1D
B1E
B1F
B20
B21
B22
B23
B24
B25
B26
F27
F28
F29
C2A
C2B
C2C
C2D
C2E
C2F
C30
C31
C32
C33
C34
C35
C36
C37
C38
C39
C3A
C3B
C3C
C3D
C3E
C3F
C40
C41
C42
C43
C44
C45
C46
C47
C48
C49
C4A
C4B
C4C
C4D
F4E
F4F
F50

// File: haar_db.sv
`timescale 1ns/100ps

module haar_db
	import haar_db_pkg::*;
#(
	parameter int NUM_STAGES = NUM_STAGES_DEF,
	parameter int DATA_WIDTH = DB_DATA_WIDTH,
	parameter int INDEX_WIDTH = DB_INDEX_WIDTH
) (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  logic                  i_start,
	input  logic                  i_enable,
	output db_word_t              o_data [NUM_STAGES],
	output db_index_t             o_index_tree [NUM_STAGES],
	output db_index_t             o_index_classifier [NUM_STAGES],
	output db_index_t             o_index_database [NUM_STAGES],
	output logic [NUM_STAGES-1:0] o_end_tree,
	output logic [NUM_STAGES-1:0] o_end_single_classifier,
	output logic [NUM_STAGES-1:0] o_end_all_classifier,
	output logic [NUM_STAGES-1:0] o_end_database,
	output logic [NUM_STAGES-1:0] o_stage_done,
	output logic                  o_end
);

	logic clear;
	logic advance;

	haar_db_launch u_launch (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_start    (i_start),
		.i_enable   (i_enable),
		.i_all_done (o_end),
		.o_clear    (clear),
		.o_advance  (advance)
	);

	for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
		haar_db_stage #(
			.NUM_CLASSIFIERS (STAGE_CLASSIFIERS[g]),
			.BASE_ADDR       (STAGE_BASE[g]),
			.DATA_WIDTH      (DATA_WIDTH),
			.INDEX_WIDTH     (INDEX_WIDTH)
		) u_stage (
			.clk                     (clk),
			.i_arst_n                (i_arst_n),
			.i_clear                 (clear),
			.i_advance               (advance),
			.o_data                  (o_data[g]),
			.o_index_tree            (o_index_tree[g]),
			.o_index_classifier      (o_index_classifier[g]),
			.o_index_database        (o_index_database[g]),
			.o_end_tree              (o_end_tree[g]),
			.o_end_single_classifier (o_end_single_classifier[g]),
			.o_end_all_classifier    (o_end_all_classifier[g]),
			.o_end_database          (o_end_database[g])
		);
	end

	haar_db_done #(
		.NUM_STAGES (NUM_STAGES)
	) u_done (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_clear      (clear),
		.i_stage_end  (o_end_database),
		.o_stage_done (o_stage_done),
		.o_all_done   (o_end)
	);

endmodule

// File: haar_db_done.sv
`timescale 1ns/100ps

module haar_db_done
	import haar_db_pkg::*;
#(
	parameter int NUM_STAGES = NUM_STAGES_DEF
) (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  logic                  i_clear,
	input  logic [NUM_STAGES-1:0] i_stage_end,
	output logic [NUM_STAGES-1:0] o_stage_done,
	output logic                  o_all_done
);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_stage_done <= '0;
		end else if (i_clear) begin
			o_stage_done <= '0;
		end else begin
			o_stage_done <= o_stage_done | i_stage_end; // Sticky.
		end
	end

	// Rises one edge behind the last flag and holds until the next clear.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_all_done <= 1'b0;
		end else if (i_clear) begin
			o_all_done <= 1'b0;
		end else begin
			o_all_done <= &o_stage_done;
		end
	end

endmodule

// File: haar_db_launch.sv
`timescale 1ns/100ps

module haar_db_launch (
	input  logic clk,
	input  logic i_arst_n,
	input  logic i_start,
	input  logic i_enable,
	input  logic i_all_done,
	output logic o_clear,
	output logic o_advance
);

	logic run;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			run <= 1'b0;
			o_clear <= 1'b0;
		end else begin
			o_clear <= i_start; // One cycle per sampled start.
			if (i_start) begin
				run <= 1'b1;
			end else if (i_all_done && !o_clear) begin
				// All-done is still stale from the last pass while clear is high.
				run <= 1'b0;
			end
		end
	end

	// Shared by every stage reader.
	assign o_advance = run && i_enable && !o_clear;

endmodule

// File: haar_db_pkg.sv
package haar_db_pkg;

	localparam int DB_DATA_WIDTH = 12;
	localparam int DB_INDEX_WIDTH = 12;

	localparam int NUM_PARAM_PER_CLASSIFIER = 18;
	localparam int WORDS_PER_TREE = 6; // Three trees per classifier.
	localparam int NUM_STAGE_THRESHOLD = 3;

	localparam int NUM_STAGES_DEF = 3;

	// Classifier count and ROM base address of each stage.
	localparam int STAGE_CLASSIFIERS [NUM_STAGES_DEF] = '{1, 1, 2};
	localparam int STAGE_BASE [NUM_STAGES_DEF] = '{0, 21, 42};

	localparam int DB_WORDS = 81;
	localparam string DB_MEM_FILE = "haar_db.mem";

	typedef logic [DB_DATA_WIDTH-1:0] db_word_t;
	typedef logic [DB_INDEX_WIDTH-1:0] db_index_t;

endpackage

// File: haar_db_stage.sv
`timescale 1ns/100ps

module haar_db_stage
	import haar_db_pkg::*;
#(
	parameter int NUM_CLASSIFIERS = 1,
	parameter int BASE_ADDR = 0,
	parameter int DATA_WIDTH = DB_DATA_WIDTH,
	parameter int INDEX_WIDTH = DB_INDEX_WIDTH
) (
	input  logic      clk,
	input  logic      i_arst_n,
	input  logic      i_clear,
	input  logic      i_advance,
	output db_word_t  o_data,
	output db_index_t o_index_tree,
	output db_index_t o_index_classifier,
	output db_index_t o_index_database,
	output logic      o_end_tree,
	output logic      o_end_single_classifier,
	output logic      o_end_all_classifier,
	output logic      o_end_database
);

	localparam int TREES_PER_CLASSIFIER = NUM_PARAM_PER_CLASSIFIER / WORDS_PER_TREE;
	localparam int STAGE_WORDS = NUM_CLASSIFIERS * NUM_PARAM_PER_CLASSIFIER
		+ NUM_STAGE_THRESHOLD;
	localparam int TW_WIDTH = $clog2(WORDS_PER_TREE);

	logic [DATA_WIDTH-1:0] rom [DB_WORDS];

	logic [INDEX_WIDTH-1:0] word_cnt;
	logic [TW_WIDTH-1:0]    tree_word;
	logic [INDEX_WIDTH-1:0] tree_cnt;
	logic [INDEX_WIDTH-1:0] cls_cnt;
	logic                   finished;

	logic step;
	logic in_threshold;
	logic last_tree_word;
	logic last_cls_word;
	logic last_all_word;
	logic last_db_word;

	initial begin
		$readmemh(DB_MEM_FILE, rom); // Each stage reads its slice at BASE_ADDR.
	end

	assign step = i_advance && !finished && !i_clear;

	// Classifier counter sits at NUM_CLASSIFIERS during the threshold words.
	assign in_threshold = (cls_cnt == NUM_CLASSIFIERS);
	assign last_tree_word = !in_threshold && (tree_word == WORDS_PER_TREE - 1);
	assign last_cls_word = last_tree_word && (tree_cnt == TREES_PER_CLASSIFIER - 1);
	assign last_all_word = last_cls_word && (cls_cnt == NUM_CLASSIFIERS - 1);
	assign last_db_word = (word_cnt == STAGE_WORDS - 1);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_data <= '0;
			o_index_database <= '0;
			o_index_classifier <= '0;
			o_index_tree <= '0;
		end else if (step) begin
			o_data <= rom[BASE_ADDR + word_cnt];
			o_index_database <= word_cnt;
			o_index_classifier <= cls_cnt;
			o_index_tree <= tree_cnt;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			word_cnt <= '0;
			tree_word <= '0;
			tree_cnt <= '0;
			cls_cnt <= '0;
			finished <= 1'b0;
			o_end_tree <= 1'b0;
			o_end_single_classifier <= 1'b0;
			o_end_all_classifier <= 1'b0;
			o_end_database <= 1'b0;
		end else if (i_clear) begin
			word_cnt <= '0;
			tree_word <= '0;
			tree_cnt <= '0;
			cls_cnt <= '0;
			finished <= 1'b0;
			o_end_tree <= 1'b0;
			o_end_single_classifier <= 1'b0;
			o_end_all_classifier <= 1'b0;
			o_end_database <= 1'b0;
		end else begin
			o_end_tree <= step && last_tree_word;
			o_end_single_classifier <= step && last_cls_word;
			o_end_all_classifier <= step && last_all_word;
			o_end_database <= step && last_db_word;
			if (step) begin
				finished <= last_db_word; // Stops after the last threshold word.
				if (!last_db_word) begin
					word_cnt <= word_cnt + 1'b1;
				end
				if (!in_threshold) begin
					if (last_tree_word) begin
						tree_word <= '0;
						if (last_cls_word) begin
							tree_cnt <= '0;
							cls_cnt <= cls_cnt + 1'b1;
						end else begin
							tree_cnt <= tree_cnt + 1'b1;
						end
					end else begin
						tree_word <= tree_word + 1'b1;
					end
				end
			end
		end
	end

endmodule

// File: haar_db_tb_model.svh
db_word_t              m_rom [DB_WORDS];
db_word_t              m_data [NUM_STAGES];
db_index_t             m_idx_tree [NUM_STAGES], m_idx_cls [NUM_STAGES], m_idx_db [NUM_STAGES];
int                    m_word [NUM_STAGES];
int                    end_pulses [NUM_STAGES];
logic [NUM_STAGES-1:0] m_fin, m_flags, m_end_tree, m_end_cls, m_end_all, m_end_db;
logic                  m_run, m_clear, m_end;
int                    err_data, err_index, err_end, err_done;

initial $readmemh(DB_MEM_FILE, m_rom);

task automatic model_reset();
	{m_run, m_clear, m_end, m_fin, m_flags} = '0;
	{m_end_tree, m_end_cls, m_end_all, m_end_db} = '0;
	foreach (m_word[s]) begin
		m_word[s] = 0;
		m_data[s] = '0;
		m_idx_tree[s] = '0;
		m_idx_cls[s] = '0;
		m_idx_db[s] = '0;
	end
endtask

// Right-hand sides all see the state from before the edge.
task automatic model_edge(logic start, logic enable);
	logic adv;
	int   w;
	int   cls_words;
	int   last;
	adv = m_run && enable && !m_clear;
	if (start) begin
		m_run = 1'b1;
	end else if (m_end && !m_clear) begin
		m_run = 1'b0;
	end
	m_end = !m_clear && (&m_flags);
	m_flags = m_clear ? '0 : (m_flags | m_end_db);
	for (int s = 0; s < NUM_STAGES; s++) begin
		w = m_word[s];
		cls_words = STAGE_CLASSIFIERS[s] * NUM_PARAM_PER_CLASSIFIER;
		last = cls_words + NUM_STAGE_THRESHOLD - 1;
		{m_end_tree[s], m_end_cls[s], m_end_all[s], m_end_db[s]} = 4'b0000;
		if (m_clear) begin
			m_word[s] = 0;
			m_fin[s] = 1'b0;
		end else if (adv && !m_fin[s]) begin
			// Threshold words read back the classifier count and tree zero.
			m_data[s] = m_rom[STAGE_BASE[s] + w];
			m_idx_db[s] = db_index_t'(w);
			m_idx_cls[s] = db_index_t'(w / NUM_PARAM_PER_CLASSIFIER);
			m_idx_tree[s] = db_index_t'((w % NUM_PARAM_PER_CLASSIFIER) / WORDS_PER_TREE);
			m_end_tree[s] = w < cls_words && (w + 1) % WORDS_PER_TREE == 0;
			m_end_cls[s] = w < cls_words && (w + 1) % NUM_PARAM_PER_CLASSIFIER == 0;
			m_end_all[s] = (w == cls_words - 1);
			m_end_db[s] = (w == last);
			m_fin[s] = (w == last);
			m_word[s] = (w == last) ? w : w + 1;
		end
	end
	m_clear = start;
endtask

task automatic check_word(string name, int s, db_word_t got, db_word_t exp);
	if (got !== exp) begin
		err_data++;
		$display("[FAIL] %s[%0d] got %h expected %h at %0t", name, s, got, exp, $time);
	end
endtask

task automatic check_index(string name, int s, db_index_t got, db_index_t exp);
	if (got !== exp) begin
		err_index++;
		$display("[FAIL] %s[%0d] got %h expected %h at %0t", name, s, got, exp, $time);
	end
endtask

task automatic check_ends(string name, logic [NUM_STAGES-1:0] got, logic [NUM_STAGES-1:0] exp);
	if (got !== exp) begin
		err_end++;
		$display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
	end
endtask

task automatic check_bit(string name, logic got, logic exp);
	if (got !== exp) begin
		err_done++;
		$display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
	end
endtask

task automatic check_outputs();
	check_ends("o_end_tree", o_end_tree, m_end_tree);
	check_ends("o_end_single_classifier", o_end_single_classifier, m_end_cls);
	check_ends("o_end_all_classifier", o_end_all_classifier, m_end_all);
	check_ends("o_end_database", o_end_database, m_end_db);
	check_ends("o_stage_done", o_stage_done, m_flags);
	check_bit("o_end", o_end, m_end);
	for (int s = 0; s < NUM_STAGES; s++) begin
		check_word("o_data", s, o_data[s], m_data[s]);
		check_index("o_index_database", s, o_index_database[s], m_idx_db[s]);
		check_index("o_index_classifier", s, o_index_classifier[s], m_idx_cls[s]);
		check_index("o_index_tree", s, o_index_tree[s], m_idx_tree[s]);
		// Pulses seen while clear is high belong to the pass being dropped.
		end_pulses[s] = m_clear ? 0 : end_pulses[s] + int'(o_end_database[s]);
	end
endtask

// File: haar_db_tb.sv
`timescale 1ns/100ps

module haar_db_tb
	import haar_db_pkg::*;
();

	localparam int NUM_STAGES = NUM_STAGES_DEF;
	localparam int CLK_PERIOD = 10;
	localparam int NUM_PASSES = 4;
	localparam int WATCHDOG_CYCLES = NUM_PASSES * (75 * 4 + 50);

	logic                  clk;
	logic                  i_arst_n;
	logic                  i_start;
	logic                  i_enable;
	db_word_t              o_data [NUM_STAGES];
	db_index_t             o_index_tree [NUM_STAGES];
	db_index_t             o_index_classifier [NUM_STAGES];
	db_index_t             o_index_database [NUM_STAGES];
	logic [NUM_STAGES-1:0] o_end_tree;
	logic [NUM_STAGES-1:0] o_end_single_classifier;
	logic [NUM_STAGES-1:0] o_end_all_classifier;
	logic [NUM_STAGES-1:0] o_end_database;
	logic [NUM_STAGES-1:0] o_stage_done;
	logic                  o_end;
	logic [31:0]           seed;

	`include "haar_db_tb_model.svh"

	haar_db #(.NUM_STAGES(NUM_STAGES)) uut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			model_reset();
		end else begin
			model_edge(i_start, i_enable);
		end
	end

	function automatic logic [31:0] lcg(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Checks what the last rising edge produced, then drives the next inputs.
	task automatic step_cycle(logic start);
		@(negedge clk);
		check_outputs();
		seed = lcg(seed);
		i_enable = (seed[31:30] != 2'b00); // About three cycles in four.
		i_start = start;
	endtask

	// o_end from the old pass is still up for two edges after a start.
	task automatic start_pass();
		step_cycle(1'b1);
		repeat (2) step_cycle(1'b0);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: a pass did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		seed = 32'h301cd37a;
		i_arst_n = 1'b0;
		i_start = 1'b0;
		i_enable = 1'b0;
		repeat (8) @(negedge clk);
		i_arst_n = 1'b1;
		repeat (6) step_cycle(1'b0); // Nothing may fire before a start.
		for (int p = 0; p < NUM_PASSES; p++) begin
			start_pass();
			if (p == 1) begin
				seed = lcg(seed);
				repeat (8 + int'(seed[31:27])) step_cycle(1'b0);
				start_pass(); // Restart mid-pass.
			end
			while (o_end !== 1'b1) begin
				step_cycle(1'b0);
			end
			seed = lcg(seed);
			repeat (2 + int'(seed[31:30])) step_cycle(1'b0); // o_end must hold.
			foreach (end_pulses[s]) begin
				if (end_pulses[s] != 1) begin
					err_end++;
					$display("Pass %0d: stage %0d gave %0d database end pulses instead of one",
						p, s, end_pulses[s]);
				end
			end
		end
		$display("Errors: data %0d, index %0d, end %0d, done %0d",
			err_data, err_index, err_end, err_done);
		if (err_data + err_index + err_end + err_done == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module haar_db_tb -f haar_db.f > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/Vhaar_db_tb > "$LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see $LOG"
	exit 1
fi
cat "$LOG"

if grep -q "ALL TESTS PASSED" "$LOG"; then
	exit 0
fi
echo "Simulation reported failures, see $LOG"
exit 1
